// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int word_bits = 16;              // Bus, register and RAM word width

    typedef logic [word_bits-1:0] word_t;

    // Bus source field, bits 14..12 when bit 15 is high
    localparam logic [2:0] src_pc   = 3'd0;
    localparam logic [2:0] src_ioh  = 3'd1;     // Immediate with FF in upper byte
    localparam logic [2:0] src_iol  = 3'd2;     // Immediate with 00 in upper byte
    localparam logic [2:0] src_ram  = 3'd3;
    localparam logic [2:0] src_x    = 3'd4;
    localparam logic [2:0] src_y    = 3'd5;
    localparam logic [2:0] src_dev  = 3'd6;
    localparam logic [2:0] src_none = 3'd7;     // Floating bus reads as zero

    // Bus destination field, bits 8..6; code 7 also loads nothing
    localparam logic [2:0] dst_none = 3'd0;
    localparam logic [2:0] dst_mar  = 3'd1;
    localparam logic [2:0] dst_ir   = 3'd2;
    localparam logic [2:0] dst_ram  = 3'd3;
    localparam logic [2:0] dst_x    = 3'd4;
    localparam logic [2:0] dst_y    = 3'd5;
    localparam logic [2:0] dst_dev  = 3'd6;

    // Microinstruction bit positions
    localparam int bit_eo_n   = 15;             // Low means ALU owns the bus
    localparam int alu_fn_msb = 14;             // EX NX EY NY F NO, down to bit 9
    localparam int src_msb    = 14;
    localparam int bit_rt     = 11;
    localparam int bit_pc_inc = 10;
    localparam int dst_msb    = 8;
    localparam int bit_jc     = 5;
    localparam int bit_jz     = 4;
    localparam int bit_jgt    = 3;
    localparam int bit_jlt    = 2;

endpackage

`default_nettype wire

// ==== control_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_decode (
    input  logic [15:0] uinstr,
    output logic [5:0]  alu_fn,
    output logic        alu_drive,
    output logic        pc_drive,
    output logic        ioh_drive,
    output logic        iol_drive,
    output logic        ram_drive,
    output logic        x_drive,
    output logic        y_drive,
    output logic        dev_drive,
    output logic        mar_load,
    output logic        ir_load,
    output logic        ram_load,
    output logic        x_load,
    output logic        y_load,
    output logic        dev_load,
    output logic        rt,
    output logic        pc_inc,
    output logic        jc,
    output logic        jz,
    output logic        jgt,
    output logic        jlt
);

    logic       eo_n;                           // High when a register drives the bus
    logic [2:0] src_sel;
    logic [2:0] dst_sel;

    assign eo_n    = uinstr[cpu_pkg::bit_eo_n];
    assign src_sel = uinstr[cpu_pkg::src_msb -: 3];
    assign dst_sel = uinstr[cpu_pkg::dst_msb -: 3];

    // ALU bits share the source field; harmless while the ALU is off the bus
    assign alu_fn    = uinstr[cpu_pkg::alu_fn_msb -: 6];
    assign alu_drive = ~eo_n;

    // Only meaningful in register-move form
    assign rt     = eo_n & uinstr[cpu_pkg::bit_rt];
    assign pc_inc = eo_n & uinstr[cpu_pkg::bit_pc_inc];

    // Jump enables are valid in both forms
    assign jc  = uinstr[cpu_pkg::bit_jc];
    assign jz  = uinstr[cpu_pkg::bit_jz];
    assign jgt = uinstr[cpu_pkg::bit_jgt];
    assign jlt = uinstr[cpu_pkg::bit_jlt];

    // Bus driver decode, enabled only by bit 15
    always_comb begin
        {pc_drive, ioh_drive, iol_drive, ram_drive} = 4'b0000;
        {x_drive, y_drive, dev_drive} = 3'b000;
        if (eo_n) begin
            case (src_sel)
                cpu_pkg::src_pc:  pc_drive  = 1'b1;
                cpu_pkg::src_ioh: ioh_drive = 1'b1;
                cpu_pkg::src_iol: iol_drive = 1'b1;
                cpu_pkg::src_ram: ram_drive = 1'b1;
                cpu_pkg::src_x:   x_drive   = 1'b1;
                cpu_pkg::src_y:   y_drive   = 1'b1;
                cpu_pkg::src_dev: dev_drive = 1'b1;
                default:          ;          // src_none, bus floats to zero
            endcase
        end
    end

    // Bus load decode, always enabled
    always_comb begin
        {mar_load, ir_load, ram_load} = 3'b000;
        {x_load, y_load, dev_load} = 3'b000;
        case (dst_sel)
            cpu_pkg::dst_mar: mar_load = 1'b1;
            cpu_pkg::dst_ir:  ir_load  = 1'b1;
            cpu_pkg::dst_ram: ram_load = 1'b1;
            cpu_pkg::dst_x:   x_load   = 1'b1;
            cpu_pkg::dst_y:   y_load   = 1'b1;
            cpu_pkg::dst_dev: dev_load = 1'b1;
            cpu_pkg::dst_none: ;
            default:          ;          // Spare code 7 loads nothing
        endcase
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [5:0]     alu_fn,
    input  cpu_pkg::word_t x,
    input  cpu_pkg::word_t y,
    output cpu_pkg::word_t result,
    output logic           carry
);

    logic ex;                                   // X enable, low zeroes X
    logic nx;                                   // Invert X after enable
    logic ey;
    logic ny;
    logic f;                                    // 1 add, 0 bitwise AND
    logic no;                                   // Invert the result

    cpu_pkg::word_t x_en;
    cpu_pkg::word_t y_en;
    cpu_pkg::word_t x_op;
    cpu_pkg::word_t y_op;
    cpu_pkg::word_t raw;

    logic [cpu_pkg::word_bits:0] sum;           // One extra bit for carry out

    assign {ex, nx, ey, ny, f, no} = alu_fn;

    // Operand conditioning
    assign x_en = ex ? x : '0;
    assign y_en = ey ? y : '0;
    assign x_op = nx ? ~x_en : x_en;
    assign y_op = ny ? ~y_en : y_en;

    assign sum = {1'b0, x_op} + {1'b0, y_op};

    always_comb begin
        if (f) begin
            raw   = sum[cpu_pkg::word_bits-1:0];
            carry = sum[cpu_pkg::word_bits];    // Carry is never inverted by NO
        end else begin
            raw   = x_op & y_op;
            carry = 1'b0;                       // No carry for AND
        end
    end

    assign result = no ? ~raw : raw;

endmodule

`default_nettype wire

// ==== ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module ram #(
    parameter int ram_addr_bits = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [ram_addr_bits-1:0] addr,
    input  cpu_pkg::word_t           wdata,
    input  logic                     write,
    output cpu_pkg::word_t           rdata
);

    localparam int depth = 1 << ram_addr_bits;

    cpu_pkg::word_t mem [depth];

    // Whole array cleared in the reset cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[addr] <= wdata;                 // Written value visible next cycle
        end
    end

    assign rdata = mem[addr];                   // Asynchronous read

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath #(
    parameter int ram_addr_bits = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    // Bus drivers, one-hot or none
    input  logic                     alu_drive,
    input  logic                     pc_drive,
    input  logic                     ioh_drive,
    input  logic                     iol_drive,
    input  logic                     ram_drive,
    input  logic                     x_drive,
    input  logic                     y_drive,
    input  logic                     dev_drive,
    // Bus loads
    input  logic                     mar_load,
    input  logic                     ir_load,
    input  logic                     x_load,
    input  logic                     y_load,
    input  logic                     dev_load,
    // Sequencing
    input  logic                     pc_inc,
    input  logic                     jc,
    input  logic                     jz,
    input  logic                     jgt,
    input  logic                     jlt,
    input  cpu_pkg::word_t           alu_result,
    input  logic                     alu_carry,
    input  cpu_pkg::word_t           ram_rdata,
    input  cpu_pkg::word_t           dev_in,
    output cpu_pkg::word_t           bus,
    output cpu_pkg::word_t           x,
    output cpu_pkg::word_t           y,
    output logic [ram_addr_bits-1:0] mar_addr,
    output cpu_pkg::word_t           pc,
    output cpu_pkg::word_t           dev_out,
    output logic                     dev_out_valid,
    output logic                     flag_c,
    output logic                     flag_z
);

    cpu_pkg::word_t ir;
    cpu_pkg::word_t imm_high;                   // IR low byte, FF above
    cpu_pkg::word_t imm_low;                    // IR low byte, zero above

    logic flag_gt;
    logic flag_lt;
    logic res_zero;
    logic res_neg;
    logic jump_taken;

    // Immediate forming from IR bits 7..0
    assign imm_high = {8'hff, ir[7:0]};
    assign imm_low  = {8'h00, ir[7:0]};

    // Wired-OR bus, zero when nothing drives
    always_comb begin
        bus = ({cpu_pkg::word_bits{alu_drive}} & alu_result)
            | ({cpu_pkg::word_bits{pc_drive}}  & pc)
            | ({cpu_pkg::word_bits{ioh_drive}} & imm_high)
            | ({cpu_pkg::word_bits{iol_drive}} & imm_low)
            | ({cpu_pkg::word_bits{ram_drive}} & ram_rdata)
            | ({cpu_pkg::word_bits{x_drive}}   & x)
            | ({cpu_pkg::word_bits{y_drive}}   & y)
            | ({cpu_pkg::word_bits{dev_drive}} & dev_in);
    end

    // General registers
    always_ff @(posedge clk) begin
        if (reset) begin
            mar_addr <= '0;
            ir       <= '0;
            x        <= '0;
            y        <= '0;
        end else begin
            if (mar_load) begin
                mar_addr <= bus[ram_addr_bits-1:0];  // Only the RAM address bits kept
            end
            if (ir_load) begin
                ir <= bus;
            end
            if (x_load) begin
                x <= bus;
            end
            if (y_load) begin
                y <= bus;
            end
        end
    end

    // Device output, valid pulses one cycle after the load
    always_ff @(posedge clk) begin
        if (reset) begin
            dev_out       <= '0;
            dev_out_valid <= 1'b0;
        end else begin
            dev_out_valid <= dev_load;
            if (dev_load) begin
                dev_out <= bus;                 // Holds until the next device write
            end
        end
    end

    assign res_zero = (alu_result == '0);
    assign res_neg  = alu_result[cpu_pkg::word_bits-1];

    // Flags change only when the ALU drives the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            flag_c  <= 1'b0;
            flag_z  <= 1'b0;
            flag_gt <= 1'b0;
            flag_lt <= 1'b0;
        end else if (alu_drive) begin
            flag_c  <= alu_carry;
            flag_z  <= res_zero;
            flag_gt <= ~res_zero & ~res_neg;
            flag_lt <= res_neg;
        end
    end

    // Condition test uses flags from before this cycle
    assign jump_taken = (jc  & flag_c)
                      | (jz  & flag_z)
                      | (jgt & flag_gt)
                      | (jlt & flag_lt);

    // Jump beats increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (jump_taken) begin
            pc <= bus;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter int ram_addr_bits = 6
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [15:0]    uinstr,
    input  cpu_pkg::word_t dev_in,
    output cpu_pkg::word_t bus,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t dev_out,
    output logic           dev_out_valid,
    output logic           rt,
    output logic           flag_c,
    output logic           flag_z
);

    logic [5:0] alu_fn;
    logic       alu_drive, pc_drive, ioh_drive, iol_drive;
    logic       ram_drive, x_drive, y_drive, dev_drive;
    logic       mar_load, ir_load, ram_load, x_load, y_load, dev_load;
    logic       pc_inc, jc, jz, jgt, jlt;
    logic       alu_carry;

    cpu_pkg::word_t           alu_result;
    cpu_pkg::word_t           x;
    cpu_pkg::word_t           y;
    cpu_pkg::word_t           ram_rdata;
    logic [ram_addr_bits-1:0] mar_addr;

    control_decode u_decode (
        .uinstr    (uinstr),
        .alu_fn    (alu_fn),
        .alu_drive (alu_drive),
        .pc_drive  (pc_drive),
        .ioh_drive (ioh_drive),
        .iol_drive (iol_drive),
        .ram_drive (ram_drive),
        .x_drive   (x_drive),
        .y_drive   (y_drive),
        .dev_drive (dev_drive),
        .mar_load  (mar_load),
        .ir_load   (ir_load),
        .ram_load  (ram_load),
        .x_load    (x_load),
        .y_load    (y_load),
        .dev_load  (dev_load),
        .rt        (rt),                        // Straight out to the sequencer
        .pc_inc    (pc_inc),
        .jc        (jc),
        .jz        (jz),
        .jgt       (jgt),
        .jlt       (jlt)
    );

    alu u_alu (
        .alu_fn (alu_fn),
        .x      (x),
        .y      (y),
        .result (alu_result),
        .carry  (alu_carry)
    );

    datapath #(
        .ram_addr_bits (ram_addr_bits)
    ) u_datapath (
        .clk           (clk),
        .reset         (reset),
        .alu_drive     (alu_drive),
        .pc_drive      (pc_drive),
        .ioh_drive     (ioh_drive),
        .iol_drive     (iol_drive),
        .ram_drive     (ram_drive),
        .x_drive       (x_drive),
        .y_drive       (y_drive),
        .dev_drive     (dev_drive),
        .mar_load      (mar_load),
        .ir_load       (ir_load),
        .x_load        (x_load),
        .y_load        (y_load),
        .dev_load      (dev_load),
        .pc_inc        (pc_inc),
        .jc            (jc),
        .jz            (jz),
        .jgt           (jgt),
        .jlt           (jlt),
        .alu_result    (alu_result),
        .alu_carry     (alu_carry),
        .ram_rdata     (ram_rdata),
        .dev_in        (dev_in),
        .bus           (bus),
        .x             (x),
        .y             (y),
        .mar_addr      (mar_addr),
        .pc            (pc),
        .dev_out       (dev_out),
        .dev_out_valid (dev_out_valid),
        .flag_c        (flag_c),
        .flag_z        (flag_z)
    );

    // RAM write strobe comes straight from the decoder
    ram #(
        .ram_addr_bits (ram_addr_bits)
    ) u_ram (
        .clk   (clk),
        .reset (reset),
        .addr  (mar_addr),
        .wdata (bus),
        .write (ram_load),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    // Held over the first rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
    parameter int ram_addr_bits = 6
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [15:0]    uinstr,
    input  cpu_pkg::word_t dev_in,
    input  cpu_pkg::word_t bus,
    input  cpu_pkg::word_t pc,
    input  cpu_pkg::word_t dev_out,
    input  logic           dev_out_valid,
    input  logic           rt,
    input  logic           flag_c,
    input  logic           flag_z,
    output int unsigned    checks,
    output int unsigned    errors
);

    // Model state as the DUT holds it between edges
    cpu_pkg::word_t           m_pc, m_ir, m_x, m_y, m_dev;
    cpu_pkg::word_t           m_ram [1 << ram_addr_bits];
    logic [ram_addr_bits-1:0] m_mar;
    logic                     m_valid, m_c, m_z, m_gt, m_lt;

    // Result in bits 15..0, carry in bit 16
    function automatic logic [16:0] alu_model(input logic [5:0] fn,
                                              input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        logic [16:0] r;
        a = fn[5] ? a : 16'h0000;               // EX then NX
        a = fn[4] ? ~a : a;
        b = fn[3] ? b : 16'h0000;               // EY then NY
        b = fn[2] ? ~b : b;
        r = fn[1] ? ({1'b0, a} + {1'b0, b}) : {1'b0, a & b};
        r[15:0] = fn[0] ? ~r[15:0] : r[15:0];   // NO leaves carry alone
        return r;
    endfunction

    task automatic compare_value(input string name, input cpu_pkg::word_t got,
                                 input cpu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // DUT outputs still hold the pre-edge state here
    always @(posedge clk) begin
        logic [15:0]    u;
        logic [16:0]    r;
        cpu_pkg::word_t b;
        logic           jump;
        u = uinstr;
        r = alu_model(u[cpu_pkg::alu_fn_msb -: 6], m_x, m_y);
        case (u[cpu_pkg::src_msb -: 3])
            cpu_pkg::src_pc:  b = m_pc;
            cpu_pkg::src_ioh: b = {8'hff, m_ir[7:0]};
            cpu_pkg::src_iol: b = {8'h00, m_ir[7:0]};
            cpu_pkg::src_ram: b = m_ram[m_mar];
            cpu_pkg::src_x:   b = m_x;
            cpu_pkg::src_y:   b = m_y;
            cpu_pkg::src_dev: b = dev_in;
            default:          b = 16'h0000;     // Undriven bus
        endcase
        if (!u[cpu_pkg::bit_eo_n]) begin
            b = r[15:0];                        // ALU form
        end
        if (reset) begin
            {m_pc, m_ir, m_x, m_y, m_dev} = '0;
            m_mar = '0;
            {m_valid, m_c, m_z, m_gt, m_lt} = '0;
            for (int i = 0; i < (1 << ram_addr_bits); i++) begin
                m_ram[i] = 16'h0000;
            end
        end else begin
            compare_value("bus", bus, b);
            compare_value("pc", pc, m_pc);
            compare_value("dev_out", dev_out, m_dev);
            compare_value("dev_out_valid", {15'd0, dev_out_valid}, {15'd0, m_valid});
            compare_value("rt", {15'd0, rt}, {15'd0, u[cpu_pkg::bit_eo_n] & u[cpu_pkg::bit_rt]});
            compare_value("flag_c", {15'd0, flag_c}, {15'd0, m_c});
            compare_value("flag_z", {15'd0, flag_z}, {15'd0, m_z});
            // Old flags decide the jump
            jump = (u[cpu_pkg::bit_jc] & m_c) | (u[cpu_pkg::bit_jz] & m_z)
                 | (u[cpu_pkg::bit_jgt] & m_gt) | (u[cpu_pkg::bit_jlt] & m_lt);
            if (jump) begin
                m_pc = b;
            end else if (u[cpu_pkg::bit_eo_n] & u[cpu_pkg::bit_pc_inc]) begin
                m_pc = m_pc + 16'd1;
            end
            m_valid = (u[cpu_pkg::dst_msb -: 3] == cpu_pkg::dst_dev);
            case (u[cpu_pkg::dst_msb -: 3])
                cpu_pkg::dst_mar: m_mar = b[ram_addr_bits-1:0];
                cpu_pkg::dst_ir:  m_ir = b;
                cpu_pkg::dst_ram: m_ram[m_mar] = b;     // Old MAR addresses the write
                cpu_pkg::dst_x:   m_x = b;
                cpu_pkg::dst_y:   m_y = b;
                cpu_pkg::dst_dev: m_dev = b;
                default:          ;
            endcase
            if (!u[cpu_pkg::bit_eo_n]) begin
                m_c  = r[16];
                m_z  = (r[15:0] == 16'h0000);
                m_lt = r[15];
                m_gt = !m_z && !m_lt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_cpu_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_sva (
    input logic           clk,
    input logic           reset,
    input logic [7:0]     drivers,              // ALU, PC, IOH, IOL, RAM, X, Y, device
    input logic           jump_taken,
    input cpu_pkg::word_t bus,
    input cpu_pkg::word_t pc,
    input logic           dev_out_valid
);

    int unsigned failures;                      // Summed into the final verdict

    one_driver: assert property (@(posedge clk) disable iff (reset) $onehot0(drivers))
        else begin
            failures++;
            $error("more than one bus driver active");
        end

    valid_after_reset: assert property (@(posedge clk) reset |=> !dev_out_valid)
        else begin
            failures++;
            $error("dev_out_valid high in the cycle after reset");
        end

    jump_loads_bus: assert property (@(posedge clk) disable iff (reset)
                                     jump_taken |=> (pc == $past(bus)))
        else begin
            failures++;
            $error("taken jump did not load the bus value into pc");
        end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int ram_addr_bits  = 6;
    localparam int reset_cycles   = 4;
    localparam int num_tests      = 5;
    localparam int test_len       = 400;
    localparam int timeout_cycles = num_tests * test_len + reset_cycles + 96;  // Plus margin
    localparam logic [15:0] idle_uinstr = 16'hf000;  // No source, no load, no jump

    logic           clk;
    logic           reset;
    logic [15:0]    uinstr;
    cpu_pkg::word_t dev_in;
    cpu_pkg::word_t bus;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t dev_out;
    logic           dev_out_valid, rt, flag_c, flag_z;
    int unsigned    checks, errors, cycles;

    string test_names [num_tests] = '{"register moves", "ALU operations", "RAM traffic",
                                      "PC sequencing", "device and rt"};

    tb_clock #(.reset_cycles(reset_cycles)) u_clock (.*);
    cpu_top #(.ram_addr_bits(ram_addr_bits)) dut (.*);
    tb_checker #(.ram_addr_bits(ram_addr_bits)) u_checker (.*);

    bind datapath tb_cpu_sva u_sva (
        .clk           (clk),
        .reset         (reset),
        .drivers       ({alu_drive, pc_drive, ioh_drive, iol_drive,
                         ram_drive, x_drive, y_drive, dev_drive}),
        .jump_taken    (jump_taken),
        .bus           (bus),
        .pc            (pc),
        .dev_out_valid (dev_out_valid)
    );

    // Random microinstruction, fields shaped per test
    function automatic logic [15:0] make_uinstr(input int test);
        logic [31:0] r;
        logic [15:0] u;
        r = $urandom;
        u = r[15:0];
        case (test)
            0: u[cpu_pkg::bit_eo_n] = 1'b1;
            1: begin
                u[cpu_pkg::bit_eo_n] = r[31] & r[30];   // Mostly ALU ops
                if (u[cpu_pkg::bit_eo_n]) begin         // Fresh X or Y from dev_in
                    u[cpu_pkg::src_msb -: 3] = cpu_pkg::src_dev;
                    u[cpu_pkg::dst_msb -: 3] = r[29] ? cpu_pkg::dst_x : cpu_pkg::dst_y;
                end
            end
            2: begin
                u[cpu_pkg::bit_eo_n] = 1'b1;
                u[cpu_pkg::src_msb -: 3] = r[31] ? cpu_pkg::src_ram
                                         : (r[30] ? cpu_pkg::src_dev : cpu_pkg::src_x);
                u[cpu_pkg::dst_msb -: 3] = r[29] ? cpu_pkg::dst_ram
                                         : (r[28] ? cpu_pkg::dst_mar : cpu_pkg::dst_x);
            end
            4: begin
                u[cpu_pkg::bit_eo_n] = 1'b1;
                if (r[31]) begin
                    u[cpu_pkg::dst_msb -: 3] = cpu_pkg::dst_dev;
                end
                if (r[30]) begin
                    u[cpu_pkg::src_msb -: 3] = cpu_pkg::src_dev;
                end
            end
            default: ;                          // PC test takes every field random
        endcase
        if (test != 3) begin
            u[cpu_pkg::bit_jc -: 4] = 4'b0000;
        end
        return u;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        int unsigned base_checks;
        int unsigned base_errors;
        void'($urandom(65));                    // One seed for the whole run
        uinstr = idle_uinstr;
        dev_in = 16'h0000;
        @(negedge reset);                       // Release lands on a falling clock edge
        for (int t = 0; t < num_tests; t++) begin
            base_checks = checks;
            base_errors = errors;
            for (int i = 0; i < test_len; i++) begin
                @(negedge clk);
                uinstr = make_uinstr(t);
                r = $urandom;
                dev_in = r[15:0];
            end
            @(negedge clk);                     // Last one checked by now
            uinstr = idle_uinstr;
            $display("test %0d %s: %0d checks, %0d errors", t + 1, test_names[t],
                     checks - base_checks, errors - base_errors);
        end
        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 num_tests, checks, errors, dut.u_datapath.u_sva.failures);
        if (errors == 0 && dut.u_datapath.u_sva.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
cpu_pkg.sv
control_decode.sv
alu.sv
ram.sv
datapath.sv
cpu_top.sv
tb_clock.sv
tb_checker.sv
tb_cpu_sva.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f --top-module tb_cpu -o tb_cpu_sim
out=$(./obj_dir/tb_cpu_sim +verilator+error+limit+1000 2>&1)
echo "$out"
echo "$out" | grep -qx "TB PASSED"
